/* Bender.yml */
package:
  name: decoding_graph

sources:
  - include_dirs:
      - include
    files:
      - hdl/dg_pkg.sv
      - hdl/neighbor_link.sv
      - hdl/processing_unit.sv
      - hdl/cluster_parity.sv
      - hdl/decoding_graph.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/dg_checker.sv
      - bench/tb_decoding_graph.sv

/* bench/dg_checker.sv */
`timescale 1ns/100ps

`include "dg_settings.svh"

module dg_checker import dg_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  stage_e                   stage_i,
    input  logic [PU_PER_ROUND-1:0]  measurements_i,
    input  logic [PU_COUNT-1:0]      odd_clusters_i,
    input  logic [PU_COUNT-1:0]      busy_i,
    input  addr_t [PU_COUNT-1:0]     roots_i,
    input  logic                     check_i,
    input  int                       test_id_i,
    output int                       pass_count_o,
    output int                       fail_count_o
);

    localparam int GX = `DG_GRID_WIDTH_X;
    localparam int GZ = `DG_GRID_WIDTH_Z;
    localparam int GU = `DG_GRID_WIDTH_U;
    localparam int WEIGHT = `DG_MAX_WEIGHT;

    // vectors of the current load burst, oldest first
    logic [GU-1:0][PU_PER_ROUND-1:0] loads_q;
    int     load_count;
    int     grow_count;
    stage_e last_stage;

    // round in the top bits, then row, then column
    function automatic addr_t node_addr(input int i);
        int u;
        int x;
        int z;
        u = i / PU_PER_ROUND;
        x = (i % PU_PER_ROUND) / GZ;
        z = i % GZ;
        return addr_t'((u << (X_BITS + Z_BITS)) | (x << Z_BITS) | z);
    endfunction

    // next node along rows, columns or rounds
    // -1 at the lattice edge
    function automatic int peer_of(input int i, input int axis);
        int x;
        x = (i % PU_PER_ROUND) / GZ;
        case (axis)
            0: return (x + 1 < GX) ? i + GZ : -1;
            1: return ((i % GZ) + 1 < GZ) ? i + 1 : -1;
            default: return (i / PU_PER_ROUND + 1 < GU) ? i + PU_PER_ROUND : -1;
        endcase
    endfunction

    // full decode of one test from the recorded loads and grow steps
    function automatic void reference_decode(
        input  logic [GU-1:0][PU_PER_ROUND-1:0] loads,
        input  int                              n_loads,
        input  int                              steps,
        output addr_t [PU_COUNT-1:0]            exp_roots,
        output logic [PU_COUNT-1:0]             exp_odd
    );
        int growth [PU_COUNT][3];
        int north [PU_COUNT];
        int south [PU_COUNT];
        int parent [PU_COUNT];
        int rep [PU_COUNT];
        logic [PU_COUNT-1:0] defect;
        logic [PU_COUNT-1:0] contact;
        logic [PU_COUNT-1:0] odd;
        int v;
        int p;
        int sum;
        int ra;
        int rb;
        int row;
        logic par;
        logic touch;
        // round k holds load n-1-(U-1-k), oldest load sinks to round 0
        for (int i = 0; i < PU_COUNT; i++) begin
            v = n_loads - GU + i / PU_PER_ROUND;
            defect[i] = (v >= 0 && v < GU) ? loads[v][i % PU_PER_ROUND] : 1'b0;
            for (int a = 0; a < 3; a++) begin
                growth[i][a] = 0;
            end
            north[i] = 0;
            south[i] = 0;
            rep[i] = i;
        end
        // singleton clusters, no boundary contact yet
        odd = defect;
        for (int s = 0; s < steps; s++) begin
            // one unit per odd endpoint, saturating at the weight
            for (int i = 0; i < PU_COUNT; i++) begin
                for (int a = 0; a < 3; a++) begin
                    p = peer_of(i, a);
                    if (p >= 0) begin
                        sum = growth[i][a] + int'(odd[i]) + int'(odd[p]);
                        growth[i][a] = (sum > WEIGHT) ? WEIGHT : sum;
                    end
                end
                row = (i % PU_PER_ROUND) / GZ;
                if (row == 0) begin
                    north[i] = (north[i] + int'(odd[i]) > WEIGHT) ? WEIGHT : north[i] + int'(odd[i]);
                end
                if (row == GX - 1) begin
                    south[i] = (south[i] + int'(odd[i]) > WEIGHT) ? WEIGHT : south[i] + int'(odd[i]);
                end
            end
            // union over fully grown links, the smaller index stays root
            for (int i = 0; i < PU_COUNT; i++) begin
                parent[i] = i;
            end
            for (int i = 0; i < PU_COUNT; i++) begin
                for (int a = 0; a < 3; a++) begin
                    p = peer_of(i, a);
                    if (p >= 0 && growth[i][a] == WEIGHT) begin
                        ra = i;
                        while (parent[ra] != ra) ra = parent[ra];
                        rb = p;
                        while (parent[rb] != rb) rb = parent[rb];
                        if (ra < rb) parent[rb] = ra;
                        else if (rb < ra) parent[ra] = rb;
                    end
                end
            end
            for (int i = 0; i < PU_COUNT; i++) begin
                ra = i;
                while (parent[ra] != ra) ra = parent[ra];
                rep[i] = ra;
                contact[i] = (north[i] == WEIGHT) || (south[i] == WEIGHT);
            end
            // cluster parity, cleared by any boundary contact
            for (int i = 0; i < PU_COUNT; i++) begin
                par = 1'b0;
                touch = 1'b0;
                for (int j = 0; j < PU_COUNT; j++) begin
                    if (rep[j] == rep[i]) begin
                        par = par ^ defect[j];
                        touch = touch | contact[j];
                    end
                end
                odd[i] = par & ~touch;
            end
        end
        for (int i = 0; i < PU_COUNT; i++) begin
            exp_roots[i] = node_addr(rep[i]);
        end
        exp_odd = odd;
    endfunction

    // record loads and grow steps as the DUT samples them
    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            loads_q <= '0;
            load_count <= 0;
            grow_count <= 0;
            last_stage <= STAGE_IDLE;
        end else begin
            last_stage <= stage_i;
            if (stage_i == STAGE_LOAD && last_stage != STAGE_LOAD) begin
                // first load of a new burst
                loads_q[0] <= measurements_i;
                load_count <= 1;
                grow_count <= 0;
            end else if (stage_i == STAGE_LOAD) begin
                if (load_count < GU) loads_q[load_count] <= measurements_i;
                load_count <= load_count + 1;
            end else if (stage_i == STAGE_GROW) begin
                grow_count <= grow_count + 1;
            end
        end
    end

    task automatic compare_outputs();
        addr_t [PU_COUNT-1:0] exp_roots;
        logic [PU_COUNT-1:0]  exp_odd;
        int errors;
        errors = 0;
        reference_decode(loads_q, load_count, grow_count, exp_roots, exp_odd);
        for (int i = 0; i < PU_COUNT; i++) begin
            if (roots_i[i] !== exp_roots[i]) begin
                $display("FAILED roots_o[%0d] expected 0x%h actual 0x%h",
                         i, exp_roots[i], roots_i[i]);
                errors++;
            end
        end
        if (odd_clusters_i !== exp_odd) begin
            $display("FAILED odd_clusters_o expected 0x%h actual 0x%h", exp_odd, odd_clusters_i);
            errors++;
        end
        // merge has settled by the time of any check
        if (busy_i !== '0) begin
            $display("FAILED busy_o expected 0x%h actual 0x%h", {PU_COUNT{1'b0}}, busy_i);
            errors++;
        end
        if (errors == 0) begin
            $display("test %0d passed, loads %0d, grow steps %0d",
                     test_id_i, load_count, grow_count);
            pass_count_o++;
        end else begin
            $display("test %0d failed with %0d mismatches", test_id_i, errors);
            fail_count_o++;
        end
    endtask

    initial begin
        pass_count_o = 0;
        fail_count_o = 0;
    end

    // outputs are stable half a cycle after the edge
    always @(negedge clk_i) begin
        if (rst_n_i && check_i) compare_outputs();
    end

endmodule

/* bench/tb_decoding_graph.sv */
`timescale 1ns/100ps

`include "dg_settings.svh"

module tb_decoding_graph import dg_pkg::*; ();

    localparam int GU = `DG_GRID_WIDTH_U;
    localparam int GZ = `DG_GRID_WIDTH_Z;
    localparam int CLK_PERIOD = 100;
    localparam int RANDOM_TESTS = 20;
    // reset, load only, adjacent pair, row 0 twice, then the random ones
    localparam int NUM_TESTS = 5 + RANDOM_TESTS;
    localparam int MAX_STEPS = 3;
    localparam int MERGE_LIMIT = PU_COUNT + 2;
    localparam int WATCHDOG_CYCLES = 3 * NUM_TESTS * (GU + MAX_STEPS * (PU_COUNT + 4)) / 2;

    // one vector per load cycle, index 0 goes in first
    typedef logic [GU-1:0][PU_PER_ROUND-1:0] load_set_t;

    logic                    clk;
    logic                    rst_n;
    stage_e                  stage;
    logic [PU_PER_ROUND-1:0] measurements;
    logic [PU_COUNT-1:0]     odd_clusters;
    logic [PU_COUNT-1:0]     busy;
    addr_t [PU_COUNT-1:0]    roots;
    logic                    check;
    int                      test_id;
    int                      pass_count;
    int                      fail_count;
    int                      merge_errors;

    always #(CLK_PERIOD / 2) clk = ~clk;

    decoding_graph DUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .stage_i        (stage),
        .measurements_i (measurements),
        .odd_clusters_o (odd_clusters),
        .busy_o         (busy),
        .roots_o        (roots)
    );

    dg_checker u_checker (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .stage_i        (stage),
        .measurements_i (measurements),
        .odd_clusters_i (odd_clusters),
        .busy_i         (busy),
        .roots_i        (roots),
        .check_i        (check),
        .test_id_i      (test_id),
        .pass_count_o   (pass_count),
        .fail_count_o   (fail_count)
    );

    // stage set here takes effect at the following edge
    task automatic next_cycle(input stage_e s);
        @(posedge clk);
        stage <= s;
    endtask

    // U load cycles then one idle so parity sees the new defects
    task automatic load_rounds(input load_set_t vectors);
        for (int i = 0; i < GU; i++) begin
            @(posedge clk);
            stage <= STAGE_LOAD;
            measurements <= vectors[i];
        end
        next_cycle(STAGE_IDLE);
    endtask

    // one grow, merge until nothing moves, two idles for parity
    task automatic grow_and_merge();
        int cycles;
        cycles = 0;
        next_cycle(STAGE_GROW);
        next_cycle(STAGE_MERGE);
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end while (busy != '0 && cycles < MERGE_LIMIT);
        if (busy != '0) begin
            $display("merge still busy after %0d cycles in test %0d", cycles, test_id);
            merge_errors++;
        end
        next_cycle(STAGE_IDLE);
        next_cycle(STAGE_IDLE);
    endtask

    // single cycle pulse that the checker samples on its negedge
    task automatic request_check(input int id);
        @(posedge clk);
        test_id <= id;
        check <= 1'b1;
        @(posedge clk);
        check <= 1'b0;
    endtask

    task automatic run_test(input int id, input load_set_t vectors, input int steps);
        test_id <= id;
        load_rounds(vectors);
        repeat (steps) grow_and_merge();
        request_check(id);
    endtask

    // ends a run that stops making progress
    initial begin : p_watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the tests did not complete", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : p_stimulus
        load_set_t vec;
        int steps;
        void'($urandom(44));
        clk = 1'b0;
        rst_n = 1'b0;
        stage = STAGE_IDLE;
        measurements = '0;
        check = 1'b0;
        test_id = 0;
        merge_errors = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // state straight out of reset
        request_check(1);

        // load only so odd flags follow the loaded defects
        for (int j = 0; j < GU; j++) vec[j] = PU_PER_ROUND'(32'h9c3 >> (3 * j));
        run_test(2, vec, 0);

        // adjacent pair in rows 1 and 2 of round 1
        vec = '0;
        vec[GU - 2][1 * GZ] = 1'b1;
        vec[GU - 2][2 * GZ] = 1'b1;
        run_test(3, vec, 1);

        // lone defect in row 0 of the newest round
        // its north boundary link is full after two steps
        vec = '0;
        vec[GU - 1][GZ - 1] = 1'b1;
        run_test(4, vec, 1);
        run_test(5, vec, 2);

        // sparse random syndromes with a quarter of the bits set
        for (int t = 0; t < RANDOM_TESTS; t++) begin
            for (int j = 0; j < GU; j++) begin
                for (int b = 0; b < PU_PER_ROUND; b++) vec[j][b] = ($urandom % 4 == 0);
            end
            steps = 1 + $urandom % MAX_STEPS;
            run_test(6 + t, vec, steps);
        end

        repeat (2) @(posedge clk);
        $display("tests passed %0d failed %0d, merge timeouts %0d",
                 pass_count, fail_count, merge_errors);
        if (fail_count == 0 && merge_errors == 0 && pass_count == NUM_TESTS) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* hdl/cluster_parity.sv */
`timescale 1ns/100ps

module cluster_parity import dg_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  addr_t [PU_COUNT-1:0]  roots_i,
    input  logic  [PU_COUNT-1:0]  defects_i,
    input  logic  [PU_COUNT-1:0]  boundary_i,
    output logic  [PU_COUNT-1:0]  odd_o
);

    logic [PU_COUNT-1:0] odd_d;
    logic [PU_COUNT-1:0] odd_q;

    // true when every pair of nodes with one root agrees on its flag
    function automatic logic flags_agree(input addr_t [PU_COUNT-1:0] roots,
                                         input logic [PU_COUNT-1:0] odd);
        logic ok;
        ok = 1'b1;
        for (int n = 0; n < PU_COUNT; n++) begin
            for (int m = n + 1; m < PU_COUNT; m++) begin
                if ((roots[n] == roots[m]) && (odd[n] != odd[m])) begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    // per node, scan all nodes of the same cluster
    // parity of their defects, cleared once any of them reaches the boundary
    always_comb begin : p_parity
        logic parity;
        logic touch;
        for (int n = 0; n < PU_COUNT; n++) begin
            parity = 1'b0;
            touch = 1'b0;
            for (int m = 0; m < PU_COUNT; m++) begin
                if (roots_i[m] == roots_i[n]) begin
                    parity = parity ^ defects_i[m];
                    touch = touch | boundary_i[m];
                end
            end
            odd_d[n] = parity & ~touch;
        end
    end

    // one cycle behind roots, defects and links
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            odd_q <= '0;
        end else begin
            odd_q <= odd_d;
        end
    end

    assign odd_o = odd_q;

    // flags of a cluster are uniform against the roots they were built from
    a_cluster_uniform: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flags_agree($past(roots_i), odd_q))
        else $error("nodes sharing a root disagree on cluster parity");

endmodule

/* hdl/decoding_graph.sv */
`timescale 1ns/100ps

`include "dg_settings.svh"

module decoding_graph import dg_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  stage_e                   stage_i,
    input  logic [PU_PER_ROUND-1:0]  measurements_i,
    output logic [PU_COUNT-1:0]      odd_clusters_o,
    output logic [PU_COUNT-1:0]      busy_o,
    output addr_t [PU_COUNT-1:0]     roots_o
);

    localparam int GX = `DG_GRID_WIDTH_X;
    localparam int GZ = `DG_GRID_WIDTH_Z;
    localparam int GU = `DG_GRID_WIDTH_U;

    // link views per node, one slot per direction
    // slots are driven by whichever link instance owns that edge
    wire link_view_t [NEIGHBOR_COUNT-1:0] views [PU_COUNT];

    logic [PU_COUNT-1:0] meas_out;
    logic [PU_COUNT-1:0] defects;
    logic [PU_COUNT-1:0] boundary;

    for (genvar u = 0; u < GU; u++) begin : g_u
        for (genvar x = 0; x < GX; x++) begin : g_x
            for (genvar z = 0; z < GZ; z++) begin : g_z
                localparam int IDX = u * PU_PER_ROUND + x * GZ + z;
                localparam addr_t ADDR =
                    addr_t'((u << (X_BITS + Z_BITS)) | (x << Z_BITS) | z);

                logic meas_in;

                // newest round takes the input, older rounds the round above
                if (u == GU - 1) begin : g_top
                    assign meas_in = measurements_i[x * GZ + z];
                end else begin : g_chain
                    assign meas_in = meas_out[IDX + PU_PER_ROUND];
                end

                processing_unit #(
                    .NODE_ADDRESS (ADDR)
                ) u_pu (
                    .clk_i    (clk_i),
                    .rst_n_i  (rst_n_i),
                    .stage_i  (stage_i),
                    .meas_i   (meas_in),
                    .meas_o   (meas_out[IDX]),
                    .links_i  (views[IDX]),
                    .root_o   (roots_o[IDX]),
                    .defect_o (defects[IDX]),
                    .busy_o   (busy_o[IDX])
                );

                // only first and last rows touch the code boundary
                assign boundary[IDX] =
                    ((x == 0) && views[IDX][DIR_NORTH].fully_grown) ||
                    ((x == GX - 1) && views[IDX][DIR_SOUTH].fully_grown);

                for (genvar d = 0; d < NEIGHBOR_COUNT; d++) begin : g_dir
                    // odd slots point to a higher row, column or round
                    localparam bit FWD = (d % 2 == 1);
                    localparam int STEP = FWD ? 1 : -1;
                    // axis 0 is rows, 1 columns, 2 rounds
                    localparam int PX = x + ((d / 2 == 0) ? STEP : 0);
                    localparam int PZ = z + ((d / 2 == 1) ? STEP : 0);
                    localparam int PR = u + ((d / 2 == 2) ? STEP : 0);
                    localparam bit HAS_PEER = (PX >= 0) && (PX < GX) &&
                                              (PZ >= 0) && (PZ < GZ) &&
                                              (PR >= 0) && (PR < GU);

                    if (HAS_PEER && FWD) begin : g_internal
                        localparam int PEER = PR * PU_PER_ROUND + PX * GZ + PZ;
                        // the lower node owns the link and fills both slots
                        neighbor_link #(
                            .IS_BOUNDARY (1'b0)
                        ) u_link (
                            .clk_i    (clk_i),
                            .rst_n_i  (rst_n_i),
                            .stage_i  (stage_i),
                            .a_grow_i (odd_clusters_o[IDX]),
                            .b_grow_i (odd_clusters_o[PEER]),
                            .a_root_i (roots_o[IDX]),
                            .b_root_i (roots_o[PEER]),
                            .a_view_o (views[IDX][d]),
                            .b_view_o (views[PEER][d ^ 1])
                        );
                    end else if (!HAS_PEER && (d / 2 == 0)) begin : g_boundary
                        // north of row 0 or south of the last row
                        neighbor_link #(
                            .IS_BOUNDARY (1'b1)
                        ) u_link (
                            .clk_i    (clk_i),
                            .rst_n_i  (rst_n_i),
                            .stage_i  (stage_i),
                            .a_grow_i (odd_clusters_o[IDX]),
                            .b_grow_i (1'b0),
                            .a_root_i (roots_o[IDX]),
                            .b_root_i (addr_t'(0)),
                            .a_view_o (views[IDX][d]),
                            .b_view_o ()
                        );
                    end else if (!HAS_PEER) begin : g_absent
                        // lattice edge with no link at all
                        assign views[IDX][d] = '0;
                    end
                end
            end
        end
    end

    cluster_parity u_parity (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .roots_i    (roots_o),
        .defects_i  (defects),
        .boundary_i (boundary),
        .odd_o      (odd_clusters_o)
    );

endmodule

/* hdl/dg_pkg.sv */
package dg_pkg;

`include "dg_settings.svh"

    // address field widths, never narrower than one bit
    localparam int X_BITS = (`DG_GRID_WIDTH_X > 1) ? $clog2(`DG_GRID_WIDTH_X) : 1;
    localparam int Z_BITS = (`DG_GRID_WIDTH_Z > 1) ? $clog2(`DG_GRID_WIDTH_Z) : 1;
    localparam int U_BITS = (`DG_GRID_WIDTH_U > 1) ? $clog2(`DG_GRID_WIDTH_U) : 1;
    localparam int ADDR_WIDTH = U_BITS + X_BITS + Z_BITS;

    localparam int PU_PER_ROUND = `DG_GRID_WIDTH_X * `DG_GRID_WIDTH_Z;
    localparam int PU_COUNT = PU_PER_ROUND * `DG_GRID_WIDTH_U;

    // growth counter must hold the full weight
    localparam int LINK_BITS = $clog2(`DG_MAX_WEIGHT + 1);

    // north, south, west, east, down, up
    localparam int NEIGHBOR_COUNT = 6;

    // global decoder stage, a level driven from outside
    typedef enum logic [1:0] {
        STAGE_IDLE  = 2'd0,
        STAGE_LOAD  = 2'd1,
        STAGE_GROW  = 2'd2,
        STAGE_MERGE = 2'd3
    } stage_e;

    // link slot of a node
    // opposite directions differ only in bit 0
    typedef enum logic [2:0] {
        DIR_NORTH = 3'd0,
        DIR_SOUTH = 3'd1,
        DIR_WEST  = 3'd2,
        DIR_EAST  = 3'd3,
        DIR_DOWN  = 3'd4,
        DIR_UP    = 3'd5
    } dir_e;

    // round in the top bits, then row, then column
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // what a link shows to one of its endpoints
    typedef struct packed {
        logic  fully_grown;
        addr_t peer_root;
    } link_view_t;

endpackage

/* hdl/neighbor_link.sv */
`timescale 1ns/100ps

`include "dg_settings.svh"

module neighbor_link import dg_pkg::*; #(
    // set for a link to the code boundary, only the a side is a node
    parameter bit IS_BOUNDARY = 1'b0
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  stage_e     stage_i,
    input  logic       a_grow_i,
    input  logic       b_grow_i,
    input  addr_t      a_root_i,
    input  addr_t      b_root_i,
    output link_view_t a_view_o,
    output link_view_t b_view_o
);

    localparam logic [LINK_BITS-1:0] WEIGHT = LINK_BITS'(`DG_MAX_WEIGHT);

    logic [LINK_BITS-1:0] growth_q;
    logic [1:0]           step;
    logic [LINK_BITS:0]   growth_sum;
    logic                 fully_grown;

    // one unit per odd endpoint
    // b side does not exist on a boundary link
    assign step = {1'b0, a_grow_i} + {1'b0, b_grow_i & ~IS_BOUNDARY};
    // extra msb catches the overshoot before saturation
    assign growth_sum = {1'b0, growth_q} + (LINK_BITS + 1)'(step);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            growth_q <= '0;
        end else begin
            case (stage_i)
                STAGE_LOAD: begin
                    growth_q <= '0;
                end
                STAGE_GROW: begin
                    // saturate at the link weight
                    if (growth_sum >= {1'b0, WEIGHT}) begin
                        growth_q <= WEIGHT;
                    end else begin
                        growth_q <= growth_sum[LINK_BITS-1:0];
                    end
                end
                default: begin
                    growth_q <= growth_q;
                end
            endcase
        end
    end

    assign fully_grown = (growth_q == WEIGHT);

    // each endpoint sees the root at the far end
    // a boundary link reflects the node's own root so it never lowers the merge
    assign a_view_o.fully_grown = fully_grown;
    assign a_view_o.peer_root   = IS_BOUNDARY ? a_root_i : b_root_i;
    assign b_view_o.fully_grown = fully_grown & ~IS_BOUNDARY;
    assign b_view_o.peer_root   = IS_BOUNDARY ? addr_t'(0) : a_root_i;

    // counter stays within the weight for any request pattern
    a_growth_bounded: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        growth_q <= WEIGHT)
        else $error("link growth %0d above weight %0d", growth_q, WEIGHT);

endmodule

/* hdl/processing_unit.sv */
`timescale 1ns/100ps

module processing_unit import dg_pkg::*; #(
    // own address, also the initial root
    parameter addr_t NODE_ADDRESS = '0
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  stage_e                           stage_i,
    input  logic                             meas_i,
    output logic                             meas_o,
    input  link_view_t [NEIGHBOR_COUNT-1:0] links_i,
    output addr_t                            root_o,
    output logic                             defect_o,
    output logic                             busy_o
);

    logic  meas_q;
    addr_t root_q;
    addr_t merged_root;
    logic  busy_q;

    // smallest root among own root and fully grown neighbors
    // boundary slots carry the own root back and drop out of the min
    always_comb begin
        merged_root = root_q;
        for (int n = 0; n < NEIGHBOR_COUNT; n++) begin
            if (links_i[n].fully_grown && (links_i[n].peer_root < merged_root)) begin
                merged_root = links_i[n].peer_root;
            end
        end
    end

    // one stage of the round shift chain
    // top round is fed from the input, lower rounds from the round above
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            meas_q <= 1'b0;
        end else if (stage_i == STAGE_LOAD) begin
            meas_q <= meas_i;
        end
    end

    // root and merge activity
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            root_q <= NODE_ADDRESS;
            busy_q <= 1'b0;
        end else begin
            case (stage_i)
                STAGE_LOAD: begin
                    // every node starts as its own cluster
                    root_q <= NODE_ADDRESS;
                    busy_q <= 1'b0;
                end
                STAGE_MERGE: begin
                    root_q <= merged_root;
                    // still moving, cluster has not settled yet
                    busy_q <= (merged_root != root_q);
                end
                default: begin
                    busy_q <= 1'b0;
                end
            endcase
        end
    end

    assign meas_o = meas_q;
    // defect is the measurement itself in this lattice
    assign defect_o = meas_q;
    assign root_o = root_q;
    assign busy_o = busy_q;

    // roots only ever flow downhill in address
    a_root_not_above_self: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        root_q <= NODE_ADDRESS)
        else $error("root %0h above node address %0h", root_q, NODE_ADDRESS);

endmodule

/* include/dg_settings.svh */
`ifndef DG_SETTINGS_SVH
`define DG_SETTINGS_SVH

// rows of processing units in one measurement round
`define DG_GRID_WIDTH_X 4

// columns of processing units in one measurement round
`define DG_GRID_WIDTH_Z 2

// number of stacked measurement rounds
`define DG_GRID_WIDTH_U 3

// growth count at which any link counts as fully grown
// every link in the lattice uses this one weight
`define DG_MAX_WEIGHT 2

`endif

/* vlog.f */
+incdir+include
hdl/dg_pkg.sv
hdl/neighbor_link.sv
hdl/processing_unit.sv
hdl/cluster_parity.sv
hdl/decoding_graph.sv
bench/dg_checker.sv
bench/tb_decoding_graph.sv
